// File: bench/clockGen.sv
// Testbench clock and reset source, 40 ns period with reset held low for the first 8 cycles
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic clk,
	output logic rst_n
);
	localparam int halfPeriod = 20;
	localparam int resetCycles = 8;

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	initial begin
		rst_n <= 1'b0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		rst_n <= 1'b1;   // Released on a falling edge like the other inputs
	end

endmodule

`default_nettype wire

// File: bench/core_assertions.sv
// Memory port protocol assertions, bound into rvCore by the testbench
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module coreAssertions (
	input logic                    clk,
	input logic                    rst_n,
	input logic [`WORD_ADDR_W-1:0] imemAddr,
	input logic                    imemStall,
	input logic                    dmemRead,
	input logic                    dmemWrite,
	input logic [`WORD_ADDR_W-1:0] dmemAddr,
	input logic [`XLEN_W-1:0]      dmemWdata,
	input logic                    dmemStall
);
	int assertFails = 0;   // Failure count

	// ========================================
	// Data port
	// ========================================
	noReadWrite: assert property (@(posedge clk) disable iff (!rst_n)
		!(dmemRead && dmemWrite))
	else begin
		$error("dmemRead and dmemWrite high together");
		assertFails++;
	end

	dmemHold: assert property (@(posedge clk) disable iff (!rst_n)
		(dmemRead || dmemWrite) && (dmemStall || imemStall) |=>
		$stable(dmemAddr) && $stable(dmemWdata) && $stable(dmemRead) && $stable(dmemWrite))
	else begin
		$error("Data port request changed while stalled");
		assertFails++;
	end

	// ========================================
	// Instruction port
	// ========================================
	imemHold: assert property (@(posedge clk) disable iff (!rst_n)
		imemStall || dmemStall |=> $stable(imemAddr))
	else begin
		$error("Fetch address changed while stalled");
		assertFails++;
	end

endmodule

`default_nettype wire

// File: bench/tbCore.sv
// Testbench for rvCore, runs a random program against an ISA model with random memory stalls
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module tbCore;
	localparam int bodyLen = 60;
	localparam int imemWords = 128;
	localparam int dmemWords = 256;
	localparam int loopIdx = bodyLen + 31;   // Final jal x0,0
	localparam int waitLimit = 5000;
	localparam logic [6:0] opcImm = 7'b0010011;
	localparam logic [6:0] opcReg = 7'b0110011;
	localparam logic [6:0] opcLoad = 7'b0000011;
	localparam logic [6:0] opcStore = 7'b0100011;
	localparam logic [6:0] opcBranch = 7'b1100011;
	localparam logic [6:0] opcJal = 7'b1101111;
	localparam logic [6:0] opcJalr = 7'b1100111;

	logic                    clk;
	logic                    rst_n;
	logic [`WORD_ADDR_W-1:0] imemAddr;
	logic [`XLEN_W-1:0]      imemRdata;
	logic                    imemStall;
	logic                    dmemRead;
	logic                    dmemWrite;
	logic [`WORD_ADDR_W-1:0] dmemAddr;
	logic [`XLEN_W-1:0]      dmemWdata;
	logic [`XLEN_W-1:0]      dmemRdata;
	logic                    dmemStall;

	integer      seed;
	int          errors;
	int          checks;
	int          storeCount;
	int          expTotal;
	bit          timedOut;
	bit          imemNew;
	bit          dmemNew;
	int          imemWait;
	int          dmemWait;
	logic [31:0] prog [imemWords];   // Encodings in register order
	logic [31:0] imem [imemWords];   // Same words as the bus sees them
	logic [31:0] busMem [dmemWords];
	logic [31:0] modelMem [dmemWords];
	logic [31:0] modelRegs [32];
	bit          isSecond [imemWords];   // jalr half of an addi/jalr pair
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];

	clockGen clockSrc (.clk(clk), .rst_n(rst_n));

	rvCore UUT (.*);

	bind rvCore coreAssertions coreChecks (.*);

	function automatic int rnd(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [31:0] swapBytes(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	function automatic logic [31:0] fillWord(input int a);
		return (32'(a) * 32'h9E37_79B9) ^ 32'h3C5A_0F96;
	endfunction

	// ========================================
	// Instruction encoders
	// ========================================
	function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, opcReg};
	endfunction

	function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opcStore};
	endfunction

	function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opcBranch};
	endfunction

	function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, opcJal};
	endfunction

	// Forward target that never splits an addi/jalr pair
	function automatic int pickTarget(input int p);
		int tgt;
		tgt = p + 1 + rnd(4);
		if (tgt > bodyLen)
			tgt = bodyLen;
		while (isSecond[tgt])
			tgt--;
		return tgt;
	endfunction

	// ========================================
	// Program generator
	// ========================================
	task automatic genProgram();
		int          p;
		int          kind;
		int          tgt;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  lastRd;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [11:0] imm;
		for (p = 0; p < imemWords; p++) begin
			prog[p] = `NOP_INSTR;
			isSecond[p] = 1'b0;
		end
		p = 4;   // First slots are loads for nonzero data
		while (p < bodyLen - 1) begin
			if (rnd(8) == 0) begin
				isSecond[p + 1] = 1'b1;
				p = p + 2;
			end else begin
				p++;
			end
		end
		lastRd = 5'd1;
		p = 0;
		while (p < bodyLen) begin
			rd = 5'(rnd(32));
			rs1 = (rnd(2) == 0) ? lastRd : 5'(rnd(32));   // Bias toward dependent pairs
			rs2 = (rnd(2) == 0) ? lastRd : 5'(rnd(32));
			f3 = 3'(rnd(8));
			if (f3 == 3'b011)
				f3 = 3'b010;   // No sltu
			kind = (p < 4) ? 9 : rnd(14);
			if (isSecond[p + 1]) begin
				rs1 = 5'(1 + rnd(31));
				tgt = pickTarget(p + 1);
				prog[p] = encI(12'(tgt * 4), 5'd0, 3'b000, rs1, opcImm);
				prog[p + 1] = encI(12'd0, rs1, 3'b000, rd, opcJalr);
				p = p + 2;
			end else begin
				if (kind <= 5) begin
					f7 = ((f3 == 3'b000 || f3 == 3'b101) && rnd(2) == 1) ? 7'h20 : 7'h00;
					prog[p] = encR(f7, rs2, rs1, f3, rd);
				end else if (kind <= 8) begin
					imm = 12'(rnd(4096));
					if (f3 == 3'b001)
						imm = {7'h00, imm[4:0]};
					else if (f3 == 3'b101)
						imm = {1'b0, imm[10], 5'h00, imm[4:0]};
					prog[p] = encI(imm, rs1, f3, rd, opcImm);
				end else if (kind <= 10) begin
					prog[p] = encI(12'h100 + 12'(4 * rnd(16)), 5'd0, 3'b010, rd, opcLoad);
				end else if (kind == 11) begin
					prog[p] = encS(12'h100 + 12'(4 * rnd(16)), rs2, 5'd0);
				end else if (kind == 12) begin
					tgt = pickTarget(p);
					prog[p] = encB(13'((tgt - p) * 4), rs2, rs1, {2'b00, f3[0]});
				end else begin
					tgt = pickTarget(p);
					prog[p] = encJ(21'((tgt - p) * 4), rd);
				end
				p++;
			end
			if ((kind <= 10 || kind == 13) && rd != 5'd0)
				lastRd = rd;
		end
		for (p = 1; p < 32; p++)
			prog[bodyLen + p - 1] = encS(12'(12'h200 + 4 * p), 5'(p), 5'd0);   // Register dump
		prog[loopIdx] = encJ(21'd0, 5'd0);
		for (p = 0; p < imemWords; p++)
			imem[p] = swapBytes(prog[p]);
	endtask

	// ========================================
	// ISA model
	// ========================================
	function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000: begin
				if (alt)
					return a - b;
				return a + b;
			end
			3'b001: return a << b[4:0];
			3'b010: return {31'd0, $signed(a) < $signed(b)};
			3'b100: return a ^ b;
			3'b101: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic runModel();
		rvPkg::instrWord w;
		logic [31:0]     raw;
		logic [31:0]     a;
		logic [31:0]     b;
		logic [31:0]     iImm;
		logic [31:0]     sImm;
		logic [31:0]     bImm;
		logic [31:0]     jImm;
		logic [31:0]     addr;
		logic [31:0]     result;
		logic            write;
		logic            taken;
		int              idx;
		int              nextIdx;
		int              steps;
		for (idx = 0; idx < 32; idx++)
			modelRegs[idx] = '0;
		idx = 0;
		steps = 0;
		while (idx != loopIdx && idx < imemWords && steps < 1000) begin
			raw = prog[idx];
			w = raw;
			a = modelRegs[w.rType.rs1];
			b = modelRegs[w.rType.rs2];
			iImm = {{20{w.iType.imm[11]}}, w.iType.imm};
			sImm = {{20{w.sType.immHi[6]}}, w.sType.immHi, w.sType.immLo};
			bImm = {{19{w.bType.imm12}}, w.bType.imm12, w.bType.imm11, w.bType.imm10to5,
				w.bType.imm4to1, 1'b0};
			jImm = {{11{raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};
			write = 1'b1;
			result = '0;
			nextIdx = idx + 1;
			case (w.rType.opcode)
				opcReg: result = aluModel(w.rType.funct3, w.rType.funct7[5], a, b);
				opcImm: result = aluModel(w.iType.funct3,
					w.iType.funct3 == 3'b101 && w.iType.imm[10], a, iImm);
				opcLoad: begin
					addr = a + iImm;
					result = modelMem[addr[9:2]];
				end
				opcStore: begin
					write = 1'b0;
					addr = a + sImm;
					modelMem[addr[9:2]] = b;
					expAddr.push_back({2'b00, addr[31:2]});
					expData.push_back(swapBytes(b));
				end
				opcBranch: begin
					write = 1'b0;
					taken = (w.bType.funct3 == 3'b000) ? (a == b) : (a != b);
					if (taken)
						nextIdx = idx + ($signed(bImm) >>> 2);
				end
				opcJal: begin
					result = 32'(idx * 4 + 4);
					nextIdx = idx + ($signed(jImm) >>> 2);
				end
				opcJalr: begin
					result = 32'(idx * 4 + 4);
					addr = (a + iImm) & ~32'd1;
					nextIdx = int'(addr[31:2]);
				end
				default: write = 1'b0;
			endcase
			if (write && w.rType.rd != 5'd0)
				modelRegs[w.rType.rd] = result;
			idx = nextIdx;
			steps++;
		end
		if (idx != loopIdx) begin
			$display("Model run did not reach the final loop at index %0d", loopIdx);
			errors++;
		end
		expTotal = expAddr.size();
	endtask

	// ========================================
	// Checks and bus monitor
	// ========================================
	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAIL %0t ns: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic recordStore();
		if (expAddr.size() == 0) begin
			errors++;
			$display("Store to word %h at %0t ns with no store left in the model", dmemAddr, $time);
		end else begin
			checkValue("dmemAddr", {2'b00, dmemAddr}, expAddr.pop_front());
			checkValue("dmemWdata", dmemWdata, expData.pop_front());
		end
		storeCount++;
		busMem[dmemAddr[7:0]] = dmemWdata;
	endtask

	// Access ends on an edge where the whole pipe moves
	always @(posedge clk) begin
		if (rst_n === 1'b1 && !imemStall && !dmemStall) begin
			imemNew = 1'b1;
			dmemNew = 1'b1;
			if (dmemWrite === 1'b1)
				recordStore();
		end
	end

	// Memories, 0 to 3 wait cycles per access
	always @(negedge clk) begin
		if (rst_n !== 1'b1) begin
			imemStall = 1'b0;
			dmemStall = 1'b0;
		end else begin
			if (imemNew) begin
				imemWait = rnd(4);
				imemNew = 1'b0;
			end
			imemStall = imemWait != 0;
			if (imemWait != 0)
				imemWait--;
			if (dmemRead || dmemWrite) begin
				if (dmemNew) begin
					dmemWait = rnd(4);
					dmemNew = 1'b0;
				end
				dmemStall = dmemWait != 0;
				if (dmemWait != 0)
					dmemWait--;
			end else begin
				dmemStall = 1'b0;
			end
		end
		if (imemAddr < imemWords)
			imemRdata = imem[imemAddr];
		else
			imemRdata = swapBytes(`NOP_INSTR);
		if (dmemRead)
			dmemRdata = busMem[dmemAddr[7:0]];
		else
			dmemRdata = '0;
	end

	task automatic finishRun();
		errors += UUT.coreChecks.assertFails;
		$display("Checks: %0d, errors: %0d, stores: %0d of %0d", checks, errors, storeCount,
			expTotal);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	endtask

	initial begin
		int cycles;
		imemRdata = swapBytes(`NOP_INSTR);
		imemStall = 1'b0;
		dmemRdata = '0;
		dmemStall = 1'b0;
		seed = 87012;
		errors = 0;
		checks = 0;
		storeCount = 0;
		timedOut = 1'b0;
		imemNew = 1'b1;
		dmemNew = 1'b1;
		imemWait = 0;
		dmemWait = 0;
		for (cycles = 0; cycles < dmemWords; cycles++) begin
			modelMem[cycles] = fillWord(cycles);
			busMem[cycles] = swapBytes(fillWord(cycles));
		end
		genProgram();
		runModel();

		cycles = 0;
		while (rst_n !== 1'b1 && cycles < 20) begin
			@(posedge clk);
			cycles++;
		end
		if (rst_n !== 1'b1) begin
			$display("Timeout waiting for reset release");
			errors++;
			timedOut = 1'b1;
		end

		if (!timedOut) begin
			@(negedge clk);
			checkValue("dmemRead", {31'd0, dmemRead}, 32'd0);
			checkValue("dmemWrite", {31'd0, dmemWrite}, 32'd0);
			cycles = 0;
			while (!(storeCount >= expTotal && imemAddr === 30'(loopIdx)) &&
				cycles < waitLimit) begin
				@(negedge clk);
				cycles++;
			end
			if (cycles >= waitLimit) begin
				$display("Timeout waiting for the program to reach its final loop");
				errors++;
				timedOut = 1'b1;
			end
		end

		if (!timedOut) begin
			repeat (10) @(negedge clk);   // Catch late stray stores
			checkValue("storeCount", 32'(storeCount), 32'(expTotal));
		end
		finishRun();
	end

endmodule

`default_nettype wire

// File: include/core_settings.svh
// Core widths, reset PC, NOP word and ALU codes, included by the design files that use them
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define XLEN_W      32
`define REG_ADDR_W  5
`define REG_COUNT   32
`define WORD_ADDR_W 30

`define RESET_PC    32'h0000_0000
`define NOP_INSTR   32'h0000_0013   // addi x0, x0, 0

// ALU codes built from funct7 bit 5 and funct3
`define ALU_ADD 4'b0000
`define ALU_SUB 4'b1000
`define ALU_SLL 4'b0001
`define ALU_SLT 4'b0010
`define ALU_XOR 4'b0100
`define ALU_SRL 4'b0101
`define ALU_SRA 4'b1101
`define ALU_OR  4'b0110
`define ALU_AND 4'b0111

`endif

// File: logic/bypassIf.sv
// Results from MEM and WB, driven by the write-back stage and read by decode and execute
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

interface bypassIf;
	logic [`REG_ADDR_W-1:0] meRd;
	logic                   meWrite;
	logic [`XLEN_W-1:0]     meData;
	logic [`REG_ADDR_W-1:0] wbRd;
	logic                   wbWrite;
	logic [`XLEN_W-1:0]     wbData;

	// Youngest match wins, x0 never matches
	function automatic logic [`XLEN_W-1:0] pick(
		input logic [`REG_ADDR_W-1:0] rs,
		input logic [`XLEN_W-1:0]     regVal
	);
		if (meWrite && meRd != '0 && meRd == rs)
			return meData;
		else if (wbWrite && wbRd != '0 && wbRd == rs)
			return wbData;
		else
			return regVal;
	endfunction

	modport source (output meRd, meWrite, meData, wbRd, wbWrite, wbData);
	modport branch (input meRd, meWrite, meData, wbRd, wbWrite, wbData, import pick);
	modport forward (input meRd, meWrite, meData, wbRd, wbWrite, wbData, import pick);
endinterface

`default_nettype wire

// File: logic/decodeStage.sv
// Decode stage with control, immediates, branch resolve, hazard detect and the ID/EX register
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module decodeStage (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   stall,
	input  rvPkg::instrWord        idInstr,
	input  logic [`XLEN_W-1:0]     idPc,
	bypassIf.branch                byp,
	output logic                   redirect,
	output logic [`XLEN_W-1:0]     redirectPc,
	output logic                   hazardStall,
	output logic                   flush,
	output logic [3:0]             aluOp,
	output logic                   aluSrc,
	output logic                   memRead,
	output logic                   memWrite,
	output logic                   memToReg,
	output logic                   regWrite,
	output logic                   isJump,
	output logic [`REG_ADDR_W-1:0] rs1,
	output logic [`REG_ADDR_W-1:0] rs2,
	output logic [`REG_ADDR_W-1:0] rd,
	output logic [`XLEN_W-1:0]     rs1Data,
	output logic [`XLEN_W-1:0]     rs2Data,
	output logic [`XLEN_W-1:0]     imm,
	output logic [`XLEN_W-1:0]     linkPc
);
	localparam logic [6:0] opcReg    = 7'b0110011;
	localparam logic [6:0] opcImm    = 7'b0010011;
	localparam logic [6:0] opcLoad   = 7'b0000011;
	localparam logic [6:0] opcStore  = 7'b0100011;
	localparam logic [6:0] opcBranch = 7'b1100011;
	localparam logic [6:0] opcJal    = 7'b1101111;
	localparam logic [6:0] opcJalr   = 7'b1100111;

	logic [6:0]             opcode;
	logic                   isR;
	logic                   isI;
	logic                   isLoad;
	logic                   isStore;
	logic                   isBranch;
	logic                   isJal;
	logic                   isJalr;
	logic                   taken;
	logic [`REG_ADDR_W-1:0] idRs1;
	logic [`REG_ADDR_W-1:0] idRs2;
	logic [`REG_ADDR_W-1:0] meLoadRd;
	logic [`XLEN_W-1:0]     rfRs1;
	logic [`XLEN_W-1:0]     rfRs2;
	logic [`XLEN_W-1:0]     opA;
	logic [`XLEN_W-1:0]     opB;
	logic [`XLEN_W-1:0]     iImm;
	logic [`XLEN_W-1:0]     sImm;
	logic [`XLEN_W-1:0]     bImm;
	logic [`XLEN_W-1:0]     jImm;
	logic [3:0]             idAluOp;
	logic                   loadUse;
	logic                   exDep;
	logic                   meDep;

	// WB writes come in over the bypass bundle
	regFile rf (.clk(clk), .rst_n(rst_n), .stall(stall), .rs1(idRs1), .rs2(idRs2),
		.rd(byp.wbRd), .wen(byp.wbWrite), .wdata(byp.wbData), .rs1Data(rfRs1), .rs2Data(rfRs2));

	// ========================================
	// Control and immediates
	// ========================================
	assign opcode = idInstr.rType.opcode;
	assign isR = opcode == opcReg;
	assign isI = opcode == opcImm;
	assign isLoad = opcode == opcLoad;
	assign isStore = opcode == opcStore;
	assign isBranch = opcode == opcBranch;
	assign isJal = opcode == opcJal;
	assign isJalr = opcode == opcJalr;
	assign idRs1 = idInstr.rType.rs1;
	assign idRs2 = idInstr.rType.rs2;

	assign iImm = {{(`XLEN_W-12){idInstr.iType.imm[11]}}, idInstr.iType.imm};
	assign sImm = {{(`XLEN_W-12){idInstr.sType.immHi[6]}}, idInstr.sType.immHi,
		idInstr.sType.immLo};
	assign bImm = {{(`XLEN_W-12){idInstr.bType.imm12}}, idInstr.bType.imm11,
		idInstr.bType.imm10to5, idInstr.bType.imm4to1, 1'b0};
	// J offset read straight off the R-format fields
	assign jImm = {{(`XLEN_W-20){idInstr.rType.funct7[6]}}, idInstr.rType.rs1,
		idInstr.rType.funct3, idInstr.rType.rs2[0], idInstr.rType.funct7[5:0],
		idInstr.rType.rs2[4:1], 1'b0};

	always_comb begin
		if (isR || (isI && idInstr.iType.funct3 == 3'b101))
			idAluOp = {idInstr.rType.funct7[5], idInstr.rType.funct3};   // srai keeps bit 30
		else if (isI)
			idAluOp = {1'b0, idInstr.iType.funct3};
		else
			idAluOp = `ALU_ADD;   // Address and don't-care
	end

	// ========================================
	// Branch and jump resolve
	// ========================================
	always_comb begin
		opA = byp.pick(idRs1, rfRs1);
		opB = byp.pick(idRs2, rfRs2);
	end

	assign taken = isJal || isJalr ||
		(isBranch && idInstr.bType.funct3 == 3'b000 && opA == opB) ||
		(isBranch && idInstr.bType.funct3 == 3'b001 && opA != opB);

	always_comb begin
		if (isJalr)
			redirectPc = (opA + iImm) & ~`XLEN_W'(1);
		else if (isJal)
			redirectPc = idPc + jImm;
		else
			redirectPc = idPc + bImm;
	end

	assign redirect = taken && !hazardStall;
	assign flush = redirect;   // Slot behind a taken transfer

	// ========================================
	// Hazards
	// ========================================
	assign loadUse = memRead && rd != '0 && (rd == idRs1 || rd == idRs2);
	assign exDep = regWrite && rd != '0 &&
		((isBranch && (rd == idRs1 || rd == idRs2)) || (isJalr && rd == idRs1));
	// Load data reaches the bypass only from WB
	assign meDep = meLoadRd != '0 &&
		((isBranch && (meLoadRd == idRs1 || meLoadRd == idRs2)) || (isJalr && meLoadRd == idRs1));
	assign hazardStall = loadUse || exDep || meDep;

	always_ff @(posedge clk) begin
		if (!rst_n)
			meLoadRd <= '0;
		else if (!stall)
			meLoadRd <= memRead ? rd : '0;
	end

	// ID/EX, hazard turns the slot into a bubble
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			memRead <= 1'b0;
			memWrite <= 1'b0;
			memToReg <= 1'b0;
			regWrite <= 1'b0;
			isJump <= 1'b0;
		end else if (!stall) begin
			memRead <= isLoad && !hazardStall;
			memWrite <= isStore && !hazardStall;
			memToReg <= isLoad && !hazardStall;
			regWrite <= (isR || isI || isLoad || isJal || isJalr) && !hazardStall;
			isJump <= (isJal || isJalr) && !hazardStall;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			aluOp <= idAluOp;
			aluSrc <= isI || isLoad || isStore;
			rs1 <= idRs1;
			rs2 <= idRs2;
			rd <= idInstr.rType.rd;
			rs1Data <= rfRs1;
			rs2Data <= rfRs2;
			imm <= isStore ? sImm : iImm;
			linkPc <= idPc + `XLEN_W'(4);
		end
	end

endmodule

`default_nettype wire

// File: logic/executeStage.sv
// Execute stage with operand forwarding, the ALU and the EX/MEM register
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module executeStage (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   stall,
	input  logic [3:0]             aluOp,
	input  logic                   aluSrc,
	input  logic                   memRead,
	input  logic                   memWrite,
	input  logic                   memToReg,
	input  logic                   regWrite,
	input  logic                   isJump,
	input  logic [`REG_ADDR_W-1:0] rs1,
	input  logic [`REG_ADDR_W-1:0] rs2,
	input  logic [`REG_ADDR_W-1:0] rd,
	input  logic [`XLEN_W-1:0]     rs1Data,
	input  logic [`XLEN_W-1:0]     rs2Data,
	input  logic [`XLEN_W-1:0]     imm,
	input  logic [`XLEN_W-1:0]     linkPc,
	bypassIf.forward               byp,
	output logic [`XLEN_W-1:0]     meAluResult,
	output logic [`XLEN_W-1:0]     meStoreData,
	output logic [`REG_ADDR_W-1:0] meRd,
	output logic                   meRegWrite,
	output logic                   meMemRead,
	output logic                   meMemWrite,
	output logic                   meMemToReg,
	output logic                   meIsJump,
	output logic [`XLEN_W-1:0]     meLinkPc
);
	logic [`XLEN_W-1:0] srcA;
	logic [`XLEN_W-1:0] fwdB;
	logic [`XLEN_W-1:0] srcB;
	logic [`XLEN_W-1:0] aluResult;
	logic [`XLEN_W-1:0] storeSwap;

	always_comb begin
		srcA = byp.pick(rs1, rs1Data);
		fwdB = byp.pick(rs2, rs2Data);   // Also the store data
		srcB = aluSrc ? imm : fwdB;
	end

	// ========================================
	// ALU
	// ========================================
	always_comb begin
		case (aluOp)
			`ALU_ADD: aluResult = srcA + srcB;
			`ALU_SUB: aluResult = srcA - srcB;
			`ALU_SLL: aluResult = srcA << srcB[4:0];
			`ALU_SLT: aluResult = `XLEN_W'($signed(srcA) < $signed(srcB));
			`ALU_XOR: aluResult = srcA ^ srcB;
			`ALU_SRL: aluResult = srcA >> srcB[4:0];
			`ALU_SRA: aluResult = $signed(srcA) >>> srcB[4:0];
			`ALU_OR:  aluResult = srcA | srcB;
			`ALU_AND: aluResult = srcA & srcB;
			default:  aluResult = '0;
		endcase
	end

	assign storeSwap = {<<8{fwdB}};   // Back to memory byte order

	// EX/MEM
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			meRegWrite <= 1'b0;
			meMemRead <= 1'b0;
			meMemWrite <= 1'b0;
			meMemToReg <= 1'b0;
			meIsJump <= 1'b0;
		end else if (!stall) begin
			meRegWrite <= regWrite;
			meMemRead <= memRead;
			meMemWrite <= memWrite;
			meMemToReg <= memToReg;
			meIsJump <= isJump;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			meAluResult <= aluResult;
			meStoreData <= storeSwap;
			meRd <= rd;
			meLinkPc <= linkPc;
		end
	end

endmodule

`default_nettype wire

// File: logic/fetchUnit.sv
// Instruction fetch with PC register, next-PC select and the IF/ID register
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module fetchUnit (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    stall,
	input  logic                    hazardStall,
	input  logic                    redirect,
	input  logic [`XLEN_W-1:0]      redirectPc,
	input  logic                    flush,
	input  logic [`XLEN_W-1:0]      imemRdata,
	output logic [`WORD_ADDR_W-1:0] imemAddr,
	output logic [`XLEN_W-1:0]      idPc,
	output rvPkg::instrWord         idInstr
);
	logic [`XLEN_W-1:0] pc;
	logic [`XLEN_W-1:0] nextPc;
	logic [`XLEN_W-1:0] fetchWord;
	logic               hold;

	assign hold = stall | hazardStall;
	assign imemAddr = pc[`XLEN_W-1:2];     // Word address
	assign fetchWord = {<<8{imemRdata}};   // Memory is little endian

	always_comb begin
		if (hold)
			nextPc = pc;
		else if (redirect)
			nextPc = redirectPc;   // Taken branch or jump from decode
		else
			nextPc = pc + `XLEN_W'(4);
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			pc <= `RESET_PC;
		else
			pc <= nextPc;
	end

	// IF/ID, wrong-path slot becomes a NOP
	always_ff @(posedge clk) begin
		if (!rst_n)
			idInstr <= `NOP_INSTR;
		else if (!hold)
			idInstr <= flush ? `NOP_INSTR : fetchWord;
	end

	always_ff @(posedge clk) begin
		if (!hold)
			idPc <= pc;
	end

endmodule

`default_nettype wire

// File: logic/memWbStage.sv
// Memory and write-back stage, registers MEM/WB and drives the bypass bundle
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module memWbStage (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   stall,
	input  logic [`XLEN_W-1:0]     meAluResult,
	input  logic [`REG_ADDR_W-1:0] meRd,
	input  logic                   meRegWrite,
	input  logic                   meMemToReg,
	input  logic                   meIsJump,
	input  logic [`XLEN_W-1:0]     meLinkPc,
	input  logic [`XLEN_W-1:0]     dmemRdata,
	bypassIf.source                byp
);
	logic [`REG_ADDR_W-1:0] wbRd;
	logic                   wbRegWrite;
	logic                   wbMemToReg;
	logic                   wbIsJump;
	logic [`XLEN_W-1:0]     wbAluResult;
	logic [`XLEN_W-1:0]     wbLoadData;
	logic [`XLEN_W-1:0]     wbLinkPc;
	logic [`XLEN_W-1:0]     loadSwap;

	assign loadSwap = {<<8{dmemRdata}};

	// MEM/WB, load data taken on the edge the data port lets go
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wbRegWrite <= 1'b0;
			wbMemToReg <= 1'b0;
			wbIsJump <= 1'b0;
		end else if (!stall) begin
			wbRegWrite <= meRegWrite;
			wbMemToReg <= meMemToReg;
			wbIsJump <= meIsJump;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			wbRd <= meRd;
			wbAluResult <= meAluResult;
			wbLoadData <= loadSwap;
			wbLinkPc <= meLinkPc;
		end
	end

	assign byp.meRd = meRd;
	assign byp.meWrite = meRegWrite;
	assign byp.meData = meIsJump ? meLinkPc : meAluResult;   // Link value for jal/jalr
	assign byp.wbRd = wbRd;
	assign byp.wbWrite = wbRegWrite;
	assign byp.wbData = wbIsJump ? wbLinkPc : (wbMemToReg ? wbLoadData : wbAluResult);

endmodule

`default_nettype wire

// File: logic/regFile.sv
// Register file with two read ports, one write port and x0 tied to zero
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module regFile (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   stall,
	input  logic [`REG_ADDR_W-1:0] rs1,
	input  logic [`REG_ADDR_W-1:0] rs2,
	input  logic [`REG_ADDR_W-1:0] rd,
	input  logic                   wen,
	input  logic [`XLEN_W-1:0]     wdata,
	output logic [`XLEN_W-1:0]     rs1Data,
	output logic [`XLEN_W-1:0]     rs2Data
);
	logic [`XLEN_W-1:0] regs [`REG_COUNT];
	logic               wrValid;

	assign wrValid = wen && rd != '0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wrValid && !stall) begin
			regs[rd] <= wdata;
		end
	end

	// Write in the same cycle shows up on the read ports
	assign rs1Data = (wrValid && rd == rs1) ? wdata : regs[rs1];
	assign rs2Data = (wrValid && rd == rs2) ? wdata : regs[rs2];

endmodule

`default_nettype wire

// File: logic/rvCore.sv
// Top of the five-stage core, connects the stages to the instruction and data ports
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module rvCore (
	input  logic                    clk,
	input  logic                    rst_n,
	output logic [`WORD_ADDR_W-1:0] imemAddr,
	input  logic [`XLEN_W-1:0]      imemRdata,
	input  logic                    imemStall,
	output logic                    dmemRead,
	output logic                    dmemWrite,
	output logic [`WORD_ADDR_W-1:0] dmemAddr,
	output logic [`XLEN_W-1:0]      dmemWdata,
	input  logic [`XLEN_W-1:0]      dmemRdata,
	input  logic                    dmemStall
);
	logic                   stall;
	logic                   hazardStall;
	logic                   redirect;
	logic [`XLEN_W-1:0]     redirectPc;
	logic                   flush;
	logic [`XLEN_W-1:0]     idPc;
	rvPkg::instrWord        idInstr;

	// ID/EX
	logic [3:0]             aluOp;
	logic                   aluSrc;
	logic                   memRead;
	logic                   memWrite;
	logic                   memToReg;
	logic                   regWrite;
	logic                   isJump;
	logic [`REG_ADDR_W-1:0] rs1;
	logic [`REG_ADDR_W-1:0] rs2;
	logic [`REG_ADDR_W-1:0] rd;
	logic [`XLEN_W-1:0]     rs1Data;
	logic [`XLEN_W-1:0]     rs2Data;
	logic [`XLEN_W-1:0]     imm;
	logic [`XLEN_W-1:0]     linkPc;

	// EX/MEM
	logic [`XLEN_W-1:0]     meAluResult;
	logic [`XLEN_W-1:0]     meStoreData;
	logic [`REG_ADDR_W-1:0] meRd;
	logic                   meRegWrite;
	logic                   meMemRead;
	logic                   meMemWrite;
	logic                   meMemToReg;
	logic                   meIsJump;
	logic [`XLEN_W-1:0]     meLinkPc;

	bypassIf byp ();

	assign stall = imemStall | dmemStall;   // Either port freezes the whole pipe

	assign dmemRead = meMemRead;
	assign dmemWrite = meMemWrite;
	assign dmemAddr = meAluResult[`XLEN_W-1:2];
	assign dmemWdata = meStoreData;

	fetchUnit uFetch (.*);
	decodeStage uDecode (.*);
	executeStage uExecute (.*);
	memWbStage uMemWb (.*);

endmodule

`default_nettype wire

// File: logic/rvPkg.sv
// Instruction word layouts shared by the decoder and the testbench ISA model
`default_nettype none

package rvPkg;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rFormat;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} iFormat;

	typedef struct packed {
		logic [6:0] immHi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		logic [6:0] opcode;
	} sFormat;

	// Scrambled branch offset, bit 0 implied zero
	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4to1;
		logic       imm11;
		logic [6:0] opcode;
	} bFormat;

	typedef union packed {
		rFormat rType;
		iFormat iType;
		sFormat sType;
		bFormat bType;
	} instrWord;

endpackage

`default_nettype wire

// File: src.f
+incdir+include
logic/rvPkg.sv
logic/bypassIf.sv
logic/fetchUnit.sv
logic/regFile.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memWbStage.sv
logic/rvCore.sv
bench/clockGen.sv
bench/core_assertions.sv
bench/tbCore.sv
